// ==== source/textTerminal_defs.svh ====
// Geometry and reset constants of the text terminal display.
// Include wherever row, column or cell widths are needed.
`ifndef TEXT_TERMINAL_DEFS_SVH
`define TEXT_TERMINAL_DEFS_SVH

`define TERM_ROWS 40            // visible text rows
`define TERM_COLS 80            // characters per row
`define TERM_CELLS 3200         // rows times columns

`define ROW_W 6                 // row index width
`define COL_W 7                 // column index width
`define CELL_W 12               // flat buffer index width

// no underline, white fg, black bg, code 0
`define BLANK_CELL 33'h0_FFF0_0000

`endif

// ==== source/termPkg.sv ====
// Cell word, register map and scanner state types of the text terminal.
// Also holds the cursor step used by both the register block and the scanner.
`include "textTerminal_defs.svh"

package termPkg;

    typedef struct packed {
        logic        underline;   // bit 32
        logic [11:0] fgColor;     // 31:20
        logic [11:0] bgColor;     // 19:8
        logic [7:0]  charCode;    // 7:0
    } termCell;

    typedef enum logic [1:0] {
        REG_CONTROL = 2'd0,
        REG_CURSOR  = 2'd1,
        REG_CHAR    = 2'd2       // address 3 unused
    } termReg;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_FILL,
        SCAN_RUN
    } scanState;

    // row-major step with wrap at the last column and the last row
    function automatic logic [`ROW_W+`COL_W-1:0] nextPos(
        input logic [`ROW_W-1:0] row,
        input logic [`COL_W-1:0] col
    );
        if (col != (`TERM_COLS - 1))
            return {row, col + 1'b1};
        else if (row != (`TERM_ROWS - 1))
            return {row + 1'b1, {`COL_W{1'b0}}};
        else
            return '0;
    endfunction

endpackage

// ==== source/bufferWriteIfc.sv ====
// Write path into the display buffer.
// The register block drives it as writer and the buffer samples it as buffer.
`include "textTerminal_defs.svh"

interface bufferWriteIfc
    import termPkg::*;
();

    logic              we;      // one-cycle write strobe
    logic [`ROW_W-1:0] row;     // target row
    logic [`COL_W-1:0] col;     // target column
    termCell           data;    // cell word to store

    modport writer (
        output we,
        output row,
        output col,
        output data
    );

    modport buffer (
        input we,
        input row,
        input col,
        input data
    );

endinterface

// ==== source/displayBuffer.sv ====
// 80x40 cell RAM behind the text terminal.
// One write port through bufferWriteIfc and one registered read port for the scanner.
`include "textTerminal_defs.svh"

module displayBuffer
    import termPkg::*;
(
    input  logic              rclk,
    input  logic [`ROW_W-1:0] readRow,
    input  logic [`COL_W-1:0] readCol,
    output termCell           readData,
    bufferWriteIfc.buffer     bufWr
);

    termCell            mem [0:`TERM_CELLS-1];
    logic [`CELL_W-1:0] writeIndex;
    logic [`CELL_W-1:0] readIndex;

    // row * stride + column at the flat index width
    assign writeIndex = `CELL_W'(bufWr.row) * `CELL_W'(`TERM_COLS) + `CELL_W'(bufWr.col);
    assign readIndex  = `CELL_W'(readRow) * `CELL_W'(`TERM_COLS) + `CELL_W'(readCol);

    initial begin
        for (int i = 0; i < `TERM_CELLS; i++) begin
            mem[i] = `BLANK_CELL;       // unwritten cells show blank
        end
    end

    always_ff @(posedge rclk) begin
        if (bufWr.we)
            mem[writeIndex] <= bufWr.data;
        readData <= mem[readIndex];     // old value on same-cell collision
    end

endmodule

// ==== source/termRegisters.sv ====
// Wishbone classic slave of the text terminal.
// Holds control bits, cursor and last CHAR word; a CHAR write stores one cell
// at the cursor and steps the cursor in row-major order.
`include "textTerminal_defs.svh"

module termRegisters
    import termPkg::*;
(
    input  logic              rclk,
    input  logic              reset,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [1:0]        adr,
    input  logic [31:0]       datIn,
    output logic [31:0]       datOut,
    output logic              ack,
    output logic              scanEnable,
    output logic              cursorEnable,
    output logic [`ROW_W-1:0] cursorRow,
    output logic [`COL_W-1:0] cursorCol,
    bufferWriteIfc.writer     bufWr
);

    termReg      regSel;
    logic        request;
    logic        writeReq;
    logic        readReq;
    logic        underlineMode;
    logic [31:0] charWord;
    logic        cursorOk;

    assign regSel   = termReg'(adr);
    assign request  = cyc & stb & ~ack;     // no new request during ack
    assign writeReq = request & we;
    assign readReq  = request & ~we;
    // both fields must be on screen
    assign cursorOk = (datIn[13:8] < `TERM_ROWS) && (datIn[6:0] < `TERM_COLS);

    always_ff @(posedge rclk) begin
        if (reset) begin
            ack           <= 1'b0;
            datOut        <= '0;
            scanEnable    <= 1'b0;
            cursorEnable  <= 1'b0;
            underlineMode <= 1'b0;
            cursorRow     <= '0;
            cursorCol     <= '0;
            charWord      <= '0;
            bufWr.we      <= 1'b0;
        end else begin
            ack      <= request;                // single-cycle ack
            bufWr.we <= 1'b0;
            if (readReq) begin
                case (regSel)
                    REG_CONTROL: datOut <= {29'b0, underlineMode, cursorEnable, scanEnable};
                    REG_CURSOR:  datOut <= {18'b0, cursorRow, 1'b0, cursorCol};
                    REG_CHAR:    datOut <= charWord;
                    default:     datOut <= '0;  // address 3
                endcase
            end
            if (writeReq) begin
                case (regSel)
                    REG_CONTROL: begin
                        scanEnable    <= datIn[0];
                        cursorEnable  <= datIn[1];
                        underlineMode <= datIn[2];
                    end
                    REG_CURSOR: begin
                        if (cursorOk) begin     // out of range keeps old cursor
                            cursorRow <= datIn[13:8];
                            cursorCol <= datIn[6:0];
                        end
                    end
                    REG_CHAR: begin
                        charWord <= datIn;
                        bufWr.we <= 1'b1;       // lands at end of ack cycle
                        {cursorRow, cursorCol} <= nextPos(cursorRow, cursorCol);
                    end
                    default: ;
                endcase
            end
        end
    end

    // write payload taken at the pre-advance cursor
    always_ff @(posedge rclk) begin
        if (writeReq && regSel == REG_CHAR) begin
            bufWr.row  <= cursorRow;
            bufWr.col  <= cursorCol;
            bufWr.data <= termCell'({underlineMode, datIn});
        end
    end

endmodule

// ==== source/cellScanner.sv ====
// Continuous row-major scan of the display buffer into a ready/valid cell stream.
// One read in flight plus one output cell; the cursor cell gets fg and bg swapped.
`include "textTerminal_defs.svh"

module cellScanner
    import termPkg::*;
(
    input  logic              rclk,
    input  logic              reset,
    input  logic              scanEnable,
    input  logic              cursorEnable,
    input  logic [`ROW_W-1:0] cursorRow,
    input  logic [`COL_W-1:0] cursorCol,
    input  termCell           readData,
    input  logic              cellReady,
    output logic [`ROW_W-1:0] readRow,
    output logic [`COL_W-1:0] readCol,
    output logic              cellValid,
    output logic [`ROW_W-1:0] cellRow,
    output logic [`COL_W-1:0] cellCol,
    output logic [7:0]        cellCode,
    output logic [11:0]       cellFg,
    output logic [11:0]       cellBg,
    output logic              cellUnderline
);

    scanState          state;
    logic [`ROW_W-1:0] posRow;      // next cell to issue
    logic [`COL_W-1:0] posCol;
    logic [`ROW_W-1:0] tagRow;      // cell whose read is in flight
    logic [`COL_W-1:0] tagCol;
    logic              tagHit;      // in-flight cell sits under the cursor
    logic              outFree;
    logic              load;
    logic              issue;
    logic              cursorHit;

    assign outFree   = ~cellValid | cellReady;      // output slot empties this edge
    assign load      = (state == SCAN_RUN) & outFree;   // in RUN a read is always in flight
    assign issue     = scanEnable & ((state == SCAN_FILL) | load);
    assign cursorHit = cursorEnable & (posRow == cursorRow) & (posCol == cursorCol);

    // while stalled keep re-reading the held cell so readData stays put
    assign readRow = (state == SCAN_RUN && !outFree) ? tagRow : posRow;
    assign readCol = (state == SCAN_RUN && !outFree) ? tagCol : posCol;

    always_ff @(posedge rclk) begin
        if (reset || !scanEnable) begin     // disable drops everything and restarts at 0
            state     <= SCAN_IDLE;
            cellValid <= 1'b0;
            posRow    <= '0;
            posCol    <= '0;
        end else begin
            case (state)
                SCAN_IDLE: state <= SCAN_FILL;
                SCAN_FILL: state <= SCAN_RUN;  // first read issued
                default:   state <= SCAN_RUN;
            endcase
            if (issue)
                {posRow, posCol} <= nextPos(posRow, posCol);
            if (load)
                cellValid <= 1'b1;
        end
    end

    always_ff @(posedge rclk) begin
        if (issue) begin
            tagRow <= posRow;
            tagCol <= posCol;
            tagHit <= cursorHit;            // cursor sampled at issue
        end
        if (load) begin
            cellRow       <= tagRow;
            cellCol       <= tagCol;
            cellCode      <= readData.charCode;
            cellFg        <= tagHit ? readData.bgColor : readData.fgColor;
            cellBg        <= tagHit ? readData.fgColor : readData.bgColor;
            cellUnderline <= readData.underline;
        end
    end

endmodule

// ==== source/textTerminal.sv ====
// Top level of the text terminal with the Wishbone register port in and the cell stream out.
// Wires the register block, display buffer and scanner together.
`include "textTerminal_defs.svh"

module textTerminal
    import termPkg::*;
(
    input  logic              rclk,
    input  logic              reset,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [1:0]        adr,
    input  logic [31:0]       datIn,
    output logic [31:0]       datOut,
    output logic              ack,
    output logic              cellValid,
    input  logic              cellReady,
    output logic [`ROW_W-1:0] cellRow,
    output logic [`COL_W-1:0] cellCol,
    output logic [7:0]        cellCode,
    output logic [11:0]       cellFg,
    output logic [11:0]       cellBg,
    output logic              cellUnderline
);

    logic              scanEnable;
    logic              cursorEnable;
    logic [`ROW_W-1:0] cursorRow;
    logic [`COL_W-1:0] cursorCol;
    logic [`ROW_W-1:0] readRow;
    logic [`COL_W-1:0] readCol;
    termCell           readData;

    bufferWriteIfc bufWr ();        // register block to buffer

    termRegisters regs (
        .rclk, .reset, .cyc, .stb, .we, .adr, .datIn, .datOut, .ack,
        .scanEnable, .cursorEnable, .cursorRow, .cursorCol,
        .bufWr (bufWr.writer)
    );

    displayBuffer buffer (
        .rclk, .readRow, .readCol, .readData,
        .bufWr (bufWr.buffer)
    );

    cellScanner scanner (
        .rclk, .reset, .scanEnable, .cursorEnable, .cursorRow, .cursorCol,
        .readData, .cellReady, .readRow, .readCol,
        .cellValid, .cellRow, .cellCol, .cellCode, .cellFg, .cellBg, .cellUnderline
    );

endmodule

// ==== sim/textTerminal_asserts.sv ====
// Protocol checks on the text terminal top level, bound into textTerminal.
// Covers Wishbone ack timing and the ready/valid cell stream rules.
`include "textTerminal_defs.svh"

module textTerminalAsserts (
    input logic              rclk,
    input logic              reset,
    input logic              cyc,
    input logic              stb,
    input logic              ack,
    input logic              cellValid,
    input logic              cellReady,
    input logic [`ROW_W-1:0] cellRow,
    input logic [`COL_W-1:0] cellCol,
    input logic [7:0]        cellCode,
    input logic [11:0]       cellFg,
    input logic [11:0]       cellBg,
    input logic              cellUnderline
);

    logic [45:0] payload;
    assign payload = {cellRow, cellCol, cellCode, cellFg, cellBg, cellUnderline};

    ackAfterRequest: assert property (@(posedge rclk) disable iff (reset)
        ack |-> $past(cyc && stb))
        else $error("ack raised without a request in the previous cycle");

    ackSingle: assert property (@(posedge rclk) disable iff (reset)
        ack |=> !ack)
        else $error("ack held for two cycles");

    // a dropped cell on scan disable is allowed
    streamHold: assert property (@(posedge rclk) disable iff (reset)
        (cellValid && !cellReady) |=> (!cellValid || $stable(payload)))
        else $error("cell payload changed while stalled");

    cellInRange: assert property (@(posedge rclk) disable iff (reset)
        cellValid |-> (cellRow < `TERM_ROWS && cellCol < `TERM_COLS))
        else $error("cell position outside the screen");

    validAfterReset: assert property (@(posedge rclk)
        reset |=> !cellValid)
        else $error("cellValid high right after reset");

endmodule

bind textTerminal textTerminalAsserts protocolChecks (
    .rclk, .reset, .cyc, .stb, .ack, .cellValid, .cellReady,
    .cellRow, .cellCol, .cellCode, .cellFg, .cellBg, .cellUnderline
);

// ==== sim/textTerminalTb.sv ====
// Testbench for the text terminal. Replays the records of the test file over Wishbone,
// mirrors every write in a shadow buffer and checks scanned frames cell by cell.
// Run from the project root so the test file path resolves.
`include "textTerminal_defs.svh"

module textTerminalTb
    import termPkg::*;
();

    logic              rclk;
    logic              reset;
    logic              cyc;
    logic              stb;
    logic              we;
    logic [1:0]        adr;
    logic [31:0]       datIn;
    logic [31:0]       datOut;
    logic              ack;
    logic              cellValid;
    logic              cellReady;
    logic [`ROW_W-1:0] cellRow;
    logic [`COL_W-1:0] cellCol;
    logic [7:0]        cellCode;
    logic [11:0]       cellFg;
    logic [11:0]       cellBg;
    logic              cellUnderline;

    termCell     shadowBuf [0:`TERM_CELLS-1];
    logic [2:0]  shadowCtrl;        // underlineMode, cursorEnable, scanEnable
    int          shadowRow;
    int          shadowCol;
    logic [31:0] shadowChar;        // last CHAR word
    logic [31:0] rngState;
    int          cycleCount;
    int          cycleLimit;        // 0 until the budget is known
    string       recKind [$];
    logic [31:0] recA [$];
    logic [31:0] recB [$];

    textTerminal uut (.*);

    always #2 rclk = ~rclk;         // period 4

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge rclk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit)
            failRun($sformatf("timeout after %0d cycles, DUT stopped responding", cycleCount));
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic checkWord(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
        if (got !== expected)
            failRun($sformatf("mismatch at %0t: %s got %h expected %h",
                              $time, name, got, expected));
    endtask

    task automatic checkCell(input termCell expected, input int row, input int col);
        termCell got;
        got = termCell'({cellUnderline, cellFg, cellBg, cellCode});
        if (cellRow !== `ROW_W'(row) || cellCol !== `COL_W'(col))
            failRun($sformatf("mismatch at %0t: cellRow,cellCol got %0d,%0d expected %0d,%0d",
                              $time, cellRow, cellCol, row, col));
        if (got !== expected)
            failRun($sformatf({"mismatch at %0t: cellUnderline,cellFg,cellBg,cellCode",
                               " at %0d,%0d got %h expected %h"},
                              $time, row, col, got, expected));
    endtask

    // shadow cell with the cursor swap applied
    function automatic termCell expectedCell(input int idx);
        termCell c;
        c = shadowBuf[idx];
        if (shadowCtrl[1] && idx == shadowRow * `TERM_COLS + shadowCol) begin
            c.fgColor = shadowBuf[idx].bgColor;
            c.bgColor = shadowBuf[idx].fgColor;
        end
        return c;
    endfunction

    function automatic logic [31:0] shadowRead(input logic [1:0] a);
        case (a)
            2'd0:    return {29'b0, shadowCtrl};
            2'd1:    return {18'b0, 6'(shadowRow), 1'b0, 7'(shadowCol)};
            2'd2:    return shadowChar;
            default: return '0;             // unused address
        endcase
    endfunction

    task automatic applyWrite(input logic [1:0] a, input logic [31:0] d);
        case (a)
            2'd0: shadowCtrl = d[2:0];
            2'd1: begin
                if (int'(d[13:8]) < `TERM_ROWS && int'(d[6:0]) < `TERM_COLS) begin
                    shadowRow = int'(d[13:8]);
                    shadowCol = int'(d[6:0]);
                end
            end
            2'd2: begin
                shadowBuf[shadowRow * `TERM_COLS + shadowCol] = termCell'({shadowCtrl[2], d});
                shadowChar = d;
                shadowCol++;                // step right and wrap at line and screen end
                if (shadowCol == `TERM_COLS) begin
                    shadowCol = 0;
                    shadowRow++;
                end
                if (shadowRow == `TERM_ROWS)
                    shadowRow = 0;
            end
            default: ;
        endcase
    endtask

    task automatic busAccess(input logic isWrite, input logic [1:0] a, input logic [31:0] d,
                             output logic [31:0] rd);
        @(posedge rclk);
        #1;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = isWrite;
        adr   = a;
        datIn = d;
        @(posedge rclk);
        #1;
        while (!ack) begin              // wait for the slave ack
            @(posedge rclk);
            #1;
        end
        rd  = datOut;                   // valid in the ack cycle
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic consumeFrame(input logic throttle, input int cells);
        int got;
        got = 0;
        while (got < cells) begin
            @(posedge rclk);
            #1;
            rngState  = xorshift32(rngState);
            cellReady = throttle ? (rngState[1:0] != 2'b00) : 1'b1;
            #1;                         // mid-cycle with outputs settled
            if (cellValid && cellReady) begin   // transfers at the coming edge
                checkCell(expectedCell(got), got / `TERM_COLS, got % `TERM_COLS);
                got++;
            end
        end
        @(posedge rclk);
        #1;
        cellReady = 1'b0;
    endtask

    initial begin
        int          fd;
        string       line;
        string       kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rd;
        rclk = 1'b0;
        reset = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        datIn = '0;
        cellReady = 1'b0;
        cycleCount = 0;
        cycleLimit = 0;
        rngState = 32'h76ff_bf76;
        shadowCtrl = '0;
        shadowRow = 0;
        shadowCol = 0;
        shadowChar = '0;
        for (int i = 0; i < `TERM_CELLS; i++)
            shadowBuf[i] = `BLANK_CELL;

        fd = $fopen("sim/textTerminal_tests.txt", "r");
        if (fd == 0)
            failRun("could not open the test file sim/textTerminal_tests.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#")
                continue;               // blank or comment
            if ($sscanf(line, "%s %h %h", kind, a, b) != 3)
                failRun({"malformed test record: ", line});
            recKind.push_back(kind);
            recA.push_back(a);
            recB.push_back(b);
        end
        $fclose(fd);
        if (recKind.size() == 0)
            failRun("the test file holds no records");

        cycleLimit = 40;                // reset and start-up slack
        foreach (recKind[i]) begin
            if (recKind[i] == "frame")
                cycleLimit += recA[i][0] ? 2 * int'(recB[i]) : int'(recB[i]) + 8;
            else if (recKind[i] == "idle")
                cycleLimit += int'(recA[i]) + 1;
            else
                cycleLimit += 3;        // one bus access
        end

        repeat (4) @(posedge rclk);
        #1;
        reset = 1'b0;

        foreach (recKind[i]) begin
            if (recKind[i] == "write") begin
                busAccess(1'b1, recA[i][1:0], recB[i], rd);
                applyWrite(recA[i][1:0], recB[i]);
            end else if (recKind[i] == "read") begin
                busAccess(1'b0, recA[i][1:0], '0, rd);
                checkWord("datOut", rd, recB[i]);
                checkWord("datOut", rd, shadowRead(recA[i][1:0]));
            end else if (recKind[i] == "frame") begin
                consumeFrame(recA[i][0], int'(recB[i]));
            end else if (recKind[i] == "idle") begin
                repeat (int'(recA[i])) @(posedge rclk);
            end else begin
                failRun({"unknown record kind in test file: ", recKind[i]});
            end
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== sim/textTerminal_tests.txt ====
# columns: kind a b, all fields hex
# write adr data | read adr expected | frame throttle cells | idle cycles 0
write 0 00000006
read 0 00000006
write 1 00000a05
read 1 00000a05
write 1 00002805
read 1 00000a05
write 1 00000a50
read 1 00000a05
read 2 00000000
write 2 fff00041
read 2 fff00041
read 1 00000a06
write 3 12345678
read 3 00000000
write 0 00000000
write 1 0000274e
write 2 0f000042
write 2 00f00043
write 2 000f0044
read 1 00000001
write 1 00000a05
write 0 00000003
frame 0 00000c80
write 0 00000000
write 0 00000001
frame 0 00000c80
write 0 00000000
write 0 00000003
frame 1 00000c80
write 0 00000000
write 0 00000003
frame 0 000001f4
write 0 00000002
idle 8 0
write 0 00000003
frame 1 00000c80
write 0 00000000
idle 4 0

// ==== textTerminal.f ====
+incdir+source
source/termPkg.sv
source/bufferWriteIfc.sv
source/displayBuffer.sv
source/termRegisters.sv
source/cellScanner.sv
source/textTerminal.sv
sim/textTerminal_asserts.sv
sim/textTerminalTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the text terminal testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module textTerminalTb -Mdir obj_dir -o textTerminalSim \
    -f textTerminal.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/textTerminalSim > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "simulation exited with status $runStatus"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "simulation ended without a pass message"
    exit 1
fi
exit 0
